/* Makefile */
# Verilator build and run of the noc_intf testbench
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = noc_intf_tb
FILELIST = sim.f
PASS_MSG = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* design/noc_intf.sv */
module noc_intf (
	input  logic clk,
	input  logic reset,
	input  logic tod_ctl,
	input  logic [noc_pkg::byte_w-1:0] tod_data,
	input  logic stopin,
	input  logic [noc_pkg::word_w-1:0] dout,
	output logic frm_ctl,
	output logic [noc_pkg::byte_w-1:0] frm_data,
	output logic pushin_q,
	output logic firstin_q,
	output logic [noc_pkg::word_w-1:0] din_q,
	output logic stopout
);
	// parser to packer
	logic [noc_pkg::byte_w-1:0] data_byte;
	logic data_valid;
	logic data_last;
	logic [noc_pkg::byte_w-1:0] pkt_dest;
	logic [noc_pkg::byte_w-1:0] pkt_src;
	logic [noc_pkg::len_w-1:0] pkt_dlen;
	// read entries from the parser
	logic rd_push;
	noc_pkg::opcode_t rd_op;
	logic [noc_pkg::byte_w-1:0] rd_dest;
	logic [noc_pkg::byte_w-1:0] rd_src;
	logic [noc_pkg::len_w-1:0] rd_len;
	// write entries from the packer
	logic wr_push;
	noc_pkg::opcode_t wr_op;
	logic [noc_pkg::byte_w-1:0] wr_dest;
	logic [noc_pkg::byte_w-1:0] wr_src;
	logic [noc_pkg::len_w-1:0] wr_len;
	logic [noc_pkg::err_w-1:0] wr_err;
	// merged fifo input
	logic push_req;
	noc_pkg::opcode_t entry_op;
	logic [noc_pkg::byte_w-1:0] entry_dest;
	logic [noc_pkg::byte_w-1:0] entry_src;
	logic [noc_pkg::len_w-1:0] entry_len;
	logic [noc_pkg::err_w-1:0] entry_err;
	// fifo head to sender
	logic not_empty;
	logic pop;
	noc_pkg::opcode_t head_op;
	logic [noc_pkg::byte_w-1:0] head_dest;
	logic [noc_pkg::byte_w-1:0] head_src;
	logic [noc_pkg::len_w-1:0] head_len;
	logic [noc_pkg::err_w-1:0] head_err;

	// one packet ends per cycle, so the two pushes never overlap
	assign push_req = rd_push | wr_push;
	assign entry_op = wr_push ? wr_op : rd_op;
	assign entry_dest = wr_push ? wr_dest : rd_dest;
	assign entry_src = wr_push ? wr_src : rd_src;
	assign entry_len = wr_push ? wr_len : rd_len;
	// reads carry no error
	assign entry_err = wr_push ? wr_err : noc_pkg::err_none;

	noc_packet_parser parser0 (
		.clk(clk), .reset(reset), .tod_ctl(tod_ctl), .tod_data(tod_data),
		.data_byte(data_byte), .data_valid(data_valid), .data_last(data_last),
		.pkt_dest(pkt_dest), .pkt_src(pkt_src), .pkt_dlen(pkt_dlen),
		.push_req(rd_push), .entry_op(rd_op), .entry_dest(rd_dest),
		.entry_src(rd_src), .entry_len(rd_len)
	);

	noc_word_packer packer0 (
		.clk(clk), .reset(reset), .data_byte(data_byte), .data_valid(data_valid),
		.data_last(data_last), .pkt_dest(pkt_dest), .pkt_src(pkt_src),
		.pkt_dlen(pkt_dlen), .stopin(stopin), .pushin_q(pushin_q),
		.firstin_q(firstin_q), .din_q(din_q), .push_req(wr_push), .entry_op(wr_op),
		.entry_dest(wr_dest), .entry_src(wr_src), .entry_len(wr_len),
		.entry_err(wr_err)
	);

	noc_resp_fifo fifo0 (
		.clk(clk), .reset(reset), .push_req(push_req), .entry_op(entry_op),
		.entry_dest(entry_dest), .entry_src(entry_src), .entry_len(entry_len),
		.entry_err(entry_err), .pop(pop), .not_empty(not_empty), .head_op(head_op),
		.head_dest(head_dest), .head_src(head_src), .head_len(head_len),
		.head_err(head_err)
	);

	noc_resp_sender sender0 (
		.clk(clk), .reset(reset), .not_empty(not_empty), .head_op(head_op),
		.head_dest(head_dest), .head_src(head_src), .head_len(head_len),
		.head_err(head_err), .dout(dout), .pop(pop), .stopout(stopout),
		.frm_ctl(frm_ctl), .frm_data(frm_data)
	);

endmodule

/* design/noc_packet_parser.sv */
module noc_packet_parser (
	input  logic clk,
	input  logic reset,
	input  logic tod_ctl,
	input  logic [noc_pkg::byte_w-1:0] tod_data,
	output logic [noc_pkg::byte_w-1:0] data_byte,
	output logic data_valid,
	output logic data_last,
	output logic [noc_pkg::byte_w-1:0] pkt_dest,
	output logic [noc_pkg::byte_w-1:0] pkt_src,
	output logic [noc_pkg::len_w-1:0] pkt_dlen,
	output logic push_req,
	output noc_pkg::opcode_t entry_op,
	output logic [noc_pkg::byte_w-1:0] entry_dest,
	output logic [noc_pkg::byte_w-1:0] entry_src,
	output logic [noc_pkg::len_w-1:0] entry_len
);
	// command byte fields
	logic [noc_pkg::alen_w-1:0] cmd_alen;
	logic [noc_pkg::dlen_w-1:0] cmd_dlen;
	logic [noc_pkg::op_w-1:0] cmd_op;
	logic cmd_known;
	noc_pkg::parse_state_t state;
	// write packet, else read
	logic pkt_write;
	// bytes still to come in the current field
	logic [noc_pkg::acnt_w-1:0] addr_left;
	logic [noc_pkg::len_w-1:0] data_left;

	assign {cmd_alen, cmd_dlen, cmd_op} = tod_data;
	// only read and write requests start a walk
	assign cmd_known = (cmd_op == noc_pkg::op_read) || (cmd_op == noc_pkg::op_write);

	// read entry fields, error code is added at the top
	assign entry_op = noc_pkg::op_read_resp;
	assign entry_dest = pkt_dest;
	assign entry_src = pkt_src;
	assign entry_len = pkt_dlen;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= noc_pkg::p_idle;
			pkt_write <= 1'b0;
			addr_left <= '0;
			data_left <= '0;
			data_valid <= 1'b0;
			data_last <= 1'b0;
			push_req <= 1'b0;
		end else begin
			data_valid <= 1'b0;
			data_last <= 1'b0;
			push_req <= 1'b0;
			if (tod_ctl) begin
				// a command byte restarts the walk
				if (cmd_known) begin
					state <= noc_pkg::p_dest;
					pkt_write <= (cmd_op == noc_pkg::op_write);
					addr_left <= noc_pkg::acnt_one << cmd_alen;
				end else begin
					state <= noc_pkg::p_idle;
				end
			end else begin
				case (state)
				noc_pkg::p_dest: begin
					state <= noc_pkg::p_src;
				end
				noc_pkg::p_src: begin
					state <= noc_pkg::p_addr;
				end
				noc_pkg::p_addr: begin
					// address bytes are skipped, only counted
					addr_left <= addr_left - 1'b1;
					if (addr_left == noc_pkg::acnt_one) begin
						if (pkt_write) begin
							data_left <= pkt_dlen;
							state <= noc_pkg::p_data;
						end else begin
							// read ends on its last address byte
							push_req <= 1'b1;
							state <= noc_pkg::p_idle;
						end
					end
				end
				noc_pkg::p_data: begin
					data_valid <= 1'b1;
					data_left <= data_left - 1'b1;
					if (data_left == noc_pkg::len_one) begin
						data_last <= 1'b1;
						state <= noc_pkg::p_idle;
					end
				end
				default: begin
					state <= noc_pkg::p_idle;
				end
				endcase
			end
		end
	end

	// packet fields held until the next packet overwrites them
	always_ff @(posedge clk) begin
		if (tod_ctl && cmd_known)
			pkt_dlen <= noc_pkg::len_one << cmd_dlen;
		if (!tod_ctl && (state == noc_pkg::p_dest))
			pkt_dest <= tod_data;
		if (!tod_ctl && (state == noc_pkg::p_src))
			pkt_src <= tod_data;
		// qualified by data_valid
		data_byte <= tod_data;
	end

endmodule

/* design/noc_pkg.sv */
package noc_pkg;

	// link and device widths
	localparam int byte_w = 8;
	localparam int word_w = 64;
	localparam int bytes_per_word = 8;
	localparam int lane_w = 3;

	// command byte layout, alen in the top bits then dlen then opcode
	localparam int alen_w = 2;
	localparam int dlen_w = 3;
	localparam int op_w = 3;

	// address byte counter, holds 1 to 8
	localparam int acnt_w = 4;
	localparam logic [acnt_w-1:0] acnt_one = acnt_w'(1);

	// data length, holds 1 to 128
	localparam int len_w = 8;
	localparam logic [len_w-1:0] len_one = len_w'(1);

	// firstin marks every 25th pushed word
	localparam int set_words = 25;
	localparam int set_w = 5;
	localparam logic [set_w-1:0] set_last = set_w'(set_words - 1);

	// last lane of a device word
	localparam logic [lane_w-1:0] lane_last = lane_w'(bytes_per_word - 1);

	// response queue
	localparam int fifo_depth = 4;
	localparam int ptr_w = 2;
	localparam int cnt_w = 3;
	localparam logic [cnt_w-1:0] fifo_full = cnt_w'(fifo_depth);

	// write error codes
	localparam int err_w = 2;
	localparam logic [err_w-1:0] err_none = 2'd0;
	localparam logic [err_w-1:0] err_drop = 2'd1;

	// zero bits between error code and opcode in a response command byte
	localparam int resp_pad_w = byte_w - err_w - op_w;

	// 5 to 7 reserved
	typedef enum logic [op_w-1:0] {
		op_nop = 3'd0,
		op_read = 3'd1,
		op_write = 3'd2,
		op_read_resp = 3'd3,
		op_write_resp = 3'd4
	} opcode_t;

	typedef enum logic [2:0] {p_idle, p_dest, p_src, p_addr, p_data} parse_state_t;

	typedef enum logic [2:0] {s_idle, s_cmd, s_dest, s_src, s_len, s_data} send_state_t;

endpackage

/* design/noc_resp_fifo.sv */
module noc_resp_fifo (
	input  logic clk,
	input  logic reset,
	input  logic push_req,
	input  noc_pkg::opcode_t entry_op,
	input  logic [noc_pkg::byte_w-1:0] entry_dest,
	input  logic [noc_pkg::byte_w-1:0] entry_src,
	input  logic [noc_pkg::len_w-1:0] entry_len,
	input  logic [noc_pkg::err_w-1:0] entry_err,
	input  logic pop,
	output logic not_empty,
	output noc_pkg::opcode_t head_op,
	output logic [noc_pkg::byte_w-1:0] head_dest,
	output logic [noc_pkg::byte_w-1:0] head_src,
	output logic [noc_pkg::len_w-1:0] head_len,
	output logic [noc_pkg::err_w-1:0] head_err
);
	// one array per entry field
	noc_pkg::opcode_t mem_op [noc_pkg::fifo_depth];
	logic [noc_pkg::byte_w-1:0] mem_dest [noc_pkg::fifo_depth];
	logic [noc_pkg::byte_w-1:0] mem_src [noc_pkg::fifo_depth];
	logic [noc_pkg::len_w-1:0] mem_len [noc_pkg::fifo_depth];
	logic [noc_pkg::err_w-1:0] mem_err [noc_pkg::fifo_depth];
	logic [noc_pkg::ptr_w-1:0] wr_ptr;
	logic [noc_pkg::ptr_w-1:0] rd_ptr;
	logic [noc_pkg::cnt_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign not_empty = (count != '0);
	// full queue drops the new entry
	assign do_push = push_req && (count != noc_pkg::fifo_full);
	assign do_pop = pop && not_empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap, depth is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (!do_push && do_pop)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_op[wr_ptr] <= entry_op;
			mem_dest[wr_ptr] <= entry_dest;
			mem_src[wr_ptr] <= entry_src;
			mem_len[wr_ptr] <= entry_len;
			mem_err[wr_ptr] <= entry_err;
		end
	end

	// oldest entry
	assign head_op = mem_op[rd_ptr];
	assign head_dest = mem_dest[rd_ptr];
	assign head_src = mem_src[rd_ptr];
	assign head_len = mem_len[rd_ptr];
	assign head_err = mem_err[rd_ptr];

endmodule

/* design/noc_resp_sender.sv */
module noc_resp_sender (
	input  logic clk,
	input  logic reset,
	input  logic not_empty,
	input  noc_pkg::opcode_t head_op,
	input  logic [noc_pkg::byte_w-1:0] head_dest,
	input  logic [noc_pkg::byte_w-1:0] head_src,
	input  logic [noc_pkg::len_w-1:0] head_len,
	input  logic [noc_pkg::err_w-1:0] head_err,
	input  logic [noc_pkg::word_w-1:0] dout,
	output logic pop,
	output logic stopout,
	output logic frm_ctl,
	output logic [noc_pkg::byte_w-1:0] frm_data
);
	// state names the byte currently on frm_data
	noc_pkg::send_state_t state;
	// popped entry
	noc_pkg::opcode_t r_op;
	logic [noc_pkg::byte_w-1:0] r_dest;
	logic [noc_pkg::byte_w-1:0] r_src;
	logic [noc_pkg::len_w-1:0] r_len;
	// device word being shifted out
	logic [noc_pkg::word_w-1:0] data_buf;
	// lane of the next data byte
	logic [noc_pkg::lane_w-1:0] lane;
	// data bytes still to send
	logic [noc_pkg::len_w-1:0] remain;
	logic is_read;
	logic load_word;
	logic [noc_pkg::byte_w-1:0] next_byte;

	// start the next response from idle only
	assign pop = (state == noc_pkg::s_idle) && not_empty;
	assign is_read = (r_op == noc_pkg::op_read_resp);

	// fetch a word the cycle before its first byte goes out
	// during the length byte and during lane 7 of each word
	assign load_word = ((state == noc_pkg::s_len) && is_read) ||
		((state == noc_pkg::s_data) && (lane == '0) && (remain != '0));
	assign stopout = !load_word;

	// lane 0 comes straight from dout, the rest from the buffer
	assign next_byte = (lane == '0) ? dout[noc_pkg::byte_w-1:0] :
		data_buf[{lane, 3'b000} +: noc_pkg::byte_w];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= noc_pkg::s_idle;
			lane <= '0;
			remain <= '0;
			frm_ctl <= 1'b1;
			frm_data <= '0;
		end else begin
			case (state)
			noc_pkg::s_idle: begin
				frm_ctl <= 1'b1;
				if (not_empty) begin
					// error code, zero pad, opcode
					frm_data <= {head_err, {noc_pkg::resp_pad_w{1'b0}}, head_op};
					state <= noc_pkg::s_cmd;
				end else begin
					// nop
					frm_data <= '0;
				end
			end
			noc_pkg::s_cmd: begin
				// ids swap, request source is the destination
				frm_ctl <= 1'b0;
				frm_data <= r_src;
				state <= noc_pkg::s_dest;
			end
			noc_pkg::s_dest: begin
				frm_data <= r_dest;
				state <= noc_pkg::s_src;
			end
			noc_pkg::s_src: begin
				frm_data <= r_len;
				lane <= '0;
				state <= noc_pkg::s_len;
			end
			noc_pkg::s_len: begin
				if (is_read) begin
					frm_data <= next_byte;
					lane <= lane + 1'b1;
					remain <= r_len - 1'b1;
					state <= noc_pkg::s_data;
				end else begin
					// write response ends with its length
					frm_ctl <= 1'b1;
					frm_data <= '0;
					state <= noc_pkg::s_idle;
				end
			end
			noc_pkg::s_data: begin
				if (remain == '0) begin
					frm_ctl <= 1'b1;
					frm_data <= '0;
					state <= noc_pkg::s_idle;
				end else begin
					frm_data <= next_byte;
					lane <= lane + 1'b1;
					remain <= remain - 1'b1;
				end
			end
			default: begin
				state <= noc_pkg::s_idle;
			end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			r_op <= head_op;
			r_dest <= head_dest;
			r_src <= head_src;
			r_len <= head_len;
		end
		if (load_word)
			data_buf <= dout;
	end

endmodule

/* design/noc_word_packer.sv */
module noc_word_packer (
	input  logic clk,
	input  logic reset,
	input  logic [noc_pkg::byte_w-1:0] data_byte,
	input  logic data_valid,
	input  logic data_last,
	input  logic [noc_pkg::byte_w-1:0] pkt_dest,
	input  logic [noc_pkg::byte_w-1:0] pkt_src,
	input  logic [noc_pkg::len_w-1:0] pkt_dlen,
	input  logic stopin,
	output logic pushin_q,
	output logic firstin_q,
	output logic [noc_pkg::word_w-1:0] din_q,
	output logic push_req,
	output noc_pkg::opcode_t entry_op,
	output logic [noc_pkg::byte_w-1:0] entry_dest,
	output logic [noc_pkg::byte_w-1:0] entry_src,
	output logic [noc_pkg::len_w-1:0] entry_len,
	output logic [noc_pkg::err_w-1:0] entry_err
);
	// lane of the incoming byte
	logic [noc_pkg::lane_w-1:0] lane;
	// position of the next pushed word in its firstin set
	logic [noc_pkg::set_w-1:0] set_cnt;
	// a word of this packet was refused
	logic err_sticky;
	logic word_done;
	logic [noc_pkg::word_w-1:0] word_buf;
	logic [noc_pkg::word_w-1:0] word_next;

	// full word or tail of the packet
	assign word_done = data_valid && ((lane == noc_pkg::lane_last) || data_last);

	always_comb begin
		// lane 0 opens a fresh word, upper lanes of a short tail stay zero
		if (lane == '0) begin
			word_next = {{(noc_pkg::word_w - noc_pkg::byte_w){1'b0}}, data_byte};
		end else begin
			word_next = word_buf;
			word_next[{lane, 3'b000} +: noc_pkg::byte_w] = data_byte;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lane <= '0;
			set_cnt <= '0;
			err_sticky <= 1'b0;
			pushin_q <= 1'b0;
			firstin_q <= 1'b0;
		end else begin
			pushin_q <= 1'b0;
			firstin_q <= 1'b0;
			if (data_valid)
				lane <= word_done ? '0 : lane + 1'b1;
			// stopin refuses the word, it is lost and not counted
			if (word_done && !stopin) begin
				pushin_q <= 1'b1;
				firstin_q <= (set_cnt == '0);
				set_cnt <= (set_cnt == noc_pkg::set_last) ? '0 : set_cnt + 1'b1;
			end
			if (data_valid && data_last)
				err_sticky <= 1'b0;
			else if (word_done && stopin)
				err_sticky <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (data_valid)
			word_buf <= word_next;
		if (word_done)
			din_q <= word_next;
	end

	// write response entry on the last data byte
	assign push_req = data_valid && data_last;
	assign entry_op = noc_pkg::op_write_resp;
	assign entry_dest = pkt_dest;
	assign entry_src = pkt_src;
	assign entry_len = pkt_dlen;
	// tail word refused in this very cycle counts too
	assign entry_err = (err_sticky || stopin) ? noc_pkg::err_drop : noc_pkg::err_none;

endmodule

/* sim.f */
+incdir+tb
design/noc_pkg.sv
design/noc_packet_parser.sv
design/noc_word_packer.sv
design/noc_resp_fifo.sv
design/noc_resp_sender.sv
design/noc_intf.sv
tb/tb_clock.sv
tb/noc_intf_tb.sv

/* tb/noc_tb_tasks.svh */
`ifndef NOC_TB_TASKS_SVH
`define NOC_TB_TASKS_SVH

// one link byte per clock, ctl marks the command byte
task automatic drive_byte(input logic ctl, input logic [7:0] data);
	@(posedge clk);
	tod_ctl <= ctl;
	tod_data <= data;
endtask

task automatic idle_link();
	@(posedge clk);
	tod_ctl <= 1'b0;
	tod_data <= 8'h00;
endtask

function automatic logic [7:0] rand_byte();
	return 8'($random(seed));
endfunction

// command byte is alen, dlen, opcode from the top bit down
task automatic send_packet(input logic [2:0] op, input int alen, input int dlen,
	input logic [7:0] dest, input logic [7:0] src, input logic [7:0] data[$]);
	int i;
	drive_byte(1'b1, {2'(alen), 3'(dlen), op});
	drive_byte(1'b0, dest);
	drive_byte(1'b0, src);
	// address bytes are random, the DUT skips them
	for (i = 0; i < (1 << alen); i++)
		drive_byte(1'b0, rand_byte());
	for (i = 0; i < data.size(); i++)
		drive_byte(1'b0, data[i]);
	idle_link();
endtask

task automatic collect_response(input string name, input int n);
	int cycles;
	cycles = 0;
	while (resp_q.size() < n) begin
		@(negedge clk);
		cycles++;
		if (cycles > resp_timeout)
			report_error($sformatf("%s timed out waiting for %0d response bytes", name, n));
	end
endtask

task automatic await_words(input string name, input int n);
	int cycles;
	cycles = 0;
	while (word_q.size() < n) begin
		@(negedge clk);
		cycles++;
		if (cycles > word_timeout)
			report_error($sformatf("%s timed out waiting for %0d device words", name, n));
	end
endtask

// ids come back swapped
task automatic verify_header(input string name, input logic [7:0] cmd,
	input logic [7:0] dest, input logic [7:0] src, input logic [7:0] len);
	compare({name, " cmd"}, {1'b1, cmd}, resp_q.pop_front());
	compare({name, " dest"}, {1'b0, src}, resp_q.pop_front());
	compare({name, " src"}, {1'b0, dest}, resp_q.pop_front());
	compare({name, " len"}, {1'b0, len}, resp_q.pop_front());
endtask

// lane 0 earliest, short tail zero padded
task automatic verify_words(input string name, input logic [7:0] data[$], input int nwords);
	logic [63:0] exp_word;
	int w;
	int i;
	await_words(name, nwords);
	compare({name, " word count"}, nwords, word_q.size());
	for (w = 0; w < nwords; w++) begin
		exp_word = '0;
		for (i = 0; (i < 8) && (w * 8 + i < data.size()); i++)
			exp_word[8 * i +: 8] = data[w * 8 + i];
		compare({name, " din"}, exp_word, word_q.pop_front());
	end
	exp_words += nwords;
endtask

// data bytes low lane first, one device word per 8 bytes
task automatic verify_read_data(input string name, input int unsigned k0, input int nbytes);
	logic [63:0] word;
	int i;
	for (i = 0; i < nbytes; i++) begin
		word = read_word(k0 + i / 8);
		compare({name, " data"}, {1'b0, word[8 * (i % 8) +: 8]}, resp_q.pop_front());
	end
	compare({name, " words taken"}, (nbytes + 7) / 8, dev_k - k0);
endtask

task automatic reset_test();
	compare("reset pushin_q", 1'b0, pushin_q);
	compare("reset firstin_q", 1'b0, firstin_q);
	compare("reset stopout", 1'b1, stopout);
	compare("reset frm_ctl", 1'b1, frm_ctl);
	compare("reset frm_data", 8'h00, frm_data);
endtask

// drop holds stopin high over the whole packet
task automatic write_test(input string name, input int dlen, input logic drop);
	logic [7:0] data[$];
	logic [7:0] dest;
	logic [7:0] src;
	int nbytes;
	int i;
	nbytes = 1 << dlen;
	dest = rand_byte();
	src = rand_byte();
	for (i = 0; i < nbytes; i++)
		data.push_back(rand_byte());
	if (drop) begin
		@(posedge clk);
		stopin <= 1'b1;
	end
	send_packet(3'd2, 1, dlen, dest, src, data);
	collect_response(name, 4);
	verify_words(name, data, drop ? 0 : (nbytes + 7) / 8);
	// error code 1 in bits 7..6 on a drop
	verify_header(name, drop ? 8'h44 : 8'h04, dest, src, 8'(nbytes));
	if (drop) begin
		@(posedge clk);
		stopin <= 1'b0;
	end
endtask

task automatic read_test(input string name, input int dlen);
	logic [7:0] none[$];
	logic [7:0] dest;
	logic [7:0] src;
	int unsigned k0;
	int nbytes;
	nbytes = 1 << dlen;
	dest = rand_byte();
	src = rand_byte();
	k0 = dev_k;
	send_packet(3'd1, 2, dlen, dest, src, none);
	collect_response(name, 4 + nbytes);
	verify_header(name, 8'h03, dest, src, 8'(nbytes));
	verify_read_data(name, k0, nbytes);
endtask

// read right behind a write, write response must lead
task automatic order_test();
	logic [7:0] data[$];
	logic [7:0] none[$];
	logic [7:0] wdest;
	logic [7:0] wsrc;
	logic [7:0] rdest;
	logic [7:0] rsrc;
	int unsigned k0;
	int i;
	wdest = rand_byte();
	wsrc = rand_byte();
	rdest = rand_byte();
	rsrc = rand_byte();
	for (i = 0; i < 8; i++)
		data.push_back(rand_byte());
	k0 = dev_k;
	send_packet(3'd2, 0, 3, wdest, wsrc, data);
	send_packet(3'd1, 0, 3, rdest, rsrc, none);
	collect_response("order", 4 + 4 + 8);
	verify_header("order write", 8'h04, wdest, wsrc, 8'd8);
	verify_words("order write", data, 1);
	verify_header("order read", 8'h03, rdest, rsrc, 8'd8);
	verify_read_data("order read", k0, 8);
endtask

// firstin on every 25th pushed word since reset
task automatic firstin_test();
	int t;
	int i;
	int n;
	for (t = 0; t < 10; t++)
		write_test("firstin write", 5, 1'b0);
	compare("firstin total words", exp_words, word_count);
	n = 0;
	for (i = 0; i < exp_words; i++) begin
		if (i % 25 == 0) begin
			compare("firstin word", i, (n < first_idx.size()) ? first_idx[n] : -1);
			n++;
		end
	end
	compare("firstin marks", n, first_idx.size());
endtask

`endif

/* tb/noc_intf_tb.sv */
module noc_intf_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// wait limits in clock cycles
	localparam int resp_timeout = 2000;
	localparam int word_timeout = 500;

	logic clk;
	logic reset;
	logic tod_ctl;
	logic [7:0] tod_data;
	logic stopin;
	// device presents pattern word 0 from the start
	logic [63:0] dout = 64'h1000_0000_0000_0000;
	logic frm_ctl;
	logic [7:0] frm_data;
	logic pushin_q;
	logic firstin_q;
	logic [63:0] din_q;
	logic stopout;

	// random stream for ids, addresses and data
	int seed;
	// index of the word the device presents on dout
	int unsigned dev_k = 0;
	// pushed words not yet checked
	logic [63:0] word_q[$];
	// word numbers since reset that carried firstin
	int first_idx[$];
	int word_count = 0;
	// words the tests expect to have been pushed
	int exp_words;
	// response bytes off the link, bit 8 is frm_ctl
	logic [8:0] resp_q[$];

	tb_clock clock0 (
		.clk(clk)
	);

	noc_intf dut0 (
		.clk(clk), .reset(reset), .tod_ctl(tod_ctl), .tod_data(tod_data),
		.stopin(stopin), .dout(dout), .frm_ctl(frm_ctl), .frm_data(frm_data),
		.pushin_q(pushin_q), .firstin_q(firstin_q), .din_q(din_q), .stopout(stopout)
	);

	// read pattern, word k
	function automatic logic [63:0] read_word(input int unsigned k);
		return 64'h1000_0000_0000_0000 + 64'(k);
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp)
		else
			report_error($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
	endtask

	`include "noc_tb_tasks.svh"

	// device model, write side records and read side pattern
	always @(posedge clk) begin
		if (pushin_q) begin
			word_q.push_back(din_q);
			if (firstin_q)
				first_idx.push_back(word_count);
			word_count <= word_count + 1;
		end
		// word taken this edge, present the next one
		if (!stopout) begin
			dout <= read_word(dev_k + 1);
			dev_k <= dev_k + 1;
		end
	end

	// response capture, nop bytes skipped
	always @(posedge clk) begin
		if (frm_ctl && (frm_data[2:0] != 3'd0))
			resp_q.push_back({1'b1, frm_data});
		else if (!frm_ctl)
			resp_q.push_back({1'b0, frm_data});
	end

	initial begin
		seed = 58;
		exp_words = 0;
		reset = 1'b1;
		tod_ctl = 1'b0;
		tod_data = 8'h00;
		stopin = 1'b0;
		// 5 cycles of reset
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_test();
		@(posedge clk);
		reset <= 1'b0;
		repeat (3) @(negedge clk);

		write_test("write16", 4, 1'b0);
		write_test("write4", 2, 1'b0);
		write_test("write_drop", 3, 1'b1);
		read_test("read16", 4);
		order_test();
		firstin_test();

		$display("Verification passed");
		$finish;
	end

endmodule

/* tb/tb_clock.sv */
module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// 20 ns period
	localparam time half_period = 10ns;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule
